//--- island_top.f
hw/island_pkg.sv
hw/island_sram_bank.sv
hw/island_soc_ctrl.sv
hw/island_periph_block.sv
hw/island_bus_demux.sv
hw/island_top.sv
sim/island_tb_properties.sv
sim/island_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the island testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module island_tb -f island_top.f --Mdir "$OBJ" -o island_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/island_tb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q ">>> FAIL" "$LOG"; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
exit 0

//--- sim/island_tb.sv
`timescale 1ns/100ps
`default_nettype none

module island_tb;
  import island_pkg::*;

  localparam addr_t PeriphBase    = 32'h0020_0000;
  localparam addr_t CtrlRegAddr   = 32'h0020_0004;
  localparam addr_t BootTableAddr = 32'h0020_0100;
  localparam int    Timeout       = 50;

  logic      clk_i;
  logic      rst_ni;
  bootmode_e bootmode_i;
  logic      fetch_enable_i;
  logic      mgr_req_i;
  logic      mgr_gnt_o;
  addr_t     mgr_addr_i;
  logic      mgr_we_i;
  be_t       mgr_be_i;
  data_t     mgr_wdata_i;
  logic      mgr_rvalid_o;
  data_t     mgr_rdata_o;
  logic      mgr_err_o;
  logic      ext_req_o;
  logic      ext_gnt_i;
  addr_t     ext_addr_o;
  logic      ext_we_o;
  be_t       ext_be_o;
  data_t     ext_wdata_o;
  logic      ext_rvalid_i;
  data_t     ext_rdata_i;
  logic      ext_err_i;
  logic      fetch_enable_o;
  addr_t     boot_addr_o;

  // Last request seen by the external responder
  addr_t seen_addr;
  logic  seen_we;
  be_t   seen_be;
  data_t seen_wdata;

  data_t shadow [addr_t];
  logic  run_done;
  logic  failed;

  island_top #(
    .BaseAddr     ( 32'h0000_0000 ),
    .BankNumBytes ( 4096          )
  ) DUT (.*);

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  // ------------------------------
  // Reporting and compare tasks
  // ------------------------------
  task automatic stop_with_failure(input string what);
    failed = 1'b1;
    $display("%s", what);
    $display(">>> FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_be(input string name, input be_t got, input be_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("error at %0t: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("error at %0t: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      stop_with_failure($sformatf("error at %0t: %s is %0d, expected %0d", $time, name, got, exp));
    end
  endtask

  function automatic data_t merge_bytes(data_t old_word, data_t new_word, be_t be);
    data_t merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

  // External responder reply rules
  function automatic data_t ext_read_word(addr_t addr);
    return ~addr;
  endfunction

  function automatic logic ext_read_err(addr_t addr);
    return &addr[3:2];
  endfunction

  // ------------------------------
  // Bus tasks
  // ------------------------------
  // Called and left a short delay after the rising edge
  task automatic issue(input addr_t addr, input logic we, input be_t be, input data_t wdata);
    int waited;
    waited = 0;
    mgr_req_i   = 1'b1;
    mgr_addr_i  = addr;
    mgr_we_i    = we;
    mgr_be_i    = be;
    mgr_wdata_i = wdata;
    @(negedge clk_i);
    while (!mgr_gnt_o) begin
      waited++;
      if (waited > Timeout) begin
        stop_with_failure("timeout: the DUT never granted the manager request");
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    mgr_req_i = 1'b0;
  endtask

  task automatic wait_response(output data_t rdata, output logic err, output int cycles);
    cycles = 0;
    do begin
      @(negedge clk_i);
      cycles++;
      if (cycles > Timeout) begin
        stop_with_failure("timeout: no response came back on the manager port");
      end
    end while (!mgr_rvalid_o);
    rdata = mgr_rdata_o;
    err   = mgr_err_o;
  endtask

  task automatic bus_access(input logic we, input addr_t addr, input be_t be,
                            input data_t wdata, output data_t rdata, output logic err,
                            output int cycles);
    issue(addr, we, be, wdata);
    wait_response(rdata, err, cycles);
    @(posedge clk_i);
    #1;
  endtask

  task automatic local_write(input addr_t addr, input be_t be, input data_t wdata);
    data_t rdata;
    logic  err;
    int    cycles;
    bus_access(1'b1, addr, be, wdata, rdata, err, cycles);
    check_bit("mgr_err_o", err, 1'b0);
    check_data("mgr_rdata_o", rdata, '0);
    check_count("write response latency", cycles, 1);
  endtask

  task automatic local_read(input addr_t addr, input data_t exp, input logic exp_err);
    data_t rdata;
    logic  err;
    int    cycles;
    bus_access(1'b0, addr, 4'hF, '0, rdata, err, cycles);
    check_bit("mgr_err_o", err, exp_err);
    check_data("mgr_rdata_o", rdata, exp);
    check_count("read response latency", cycles, 1);
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------
  task automatic test_boot_state;
    soc_ctrl_word_u exp_ctrl;
    exp_ctrl.raw             = '0;
    exp_ctrl.fields.bootmode = BootJtag;
    exp_ctrl.fields.fetchen  = 1'b1;
    check_bit("fetch_enable_o", fetch_enable_o, 1'b1);
    check_addr("boot_addr_o", boot_addr_o, 32'h0020_0180);
    local_read(CtrlRegAddr, exp_ctrl.raw, 1'b0);
  endtask

  task automatic test_banks;
    addr_t addrs [4];
    data_t wdata;
    be_t   be;
    addrs = '{32'h0000_0010, 32'h0000_0ffc, 32'h0000_1010, 32'h0000_1ffc};
    foreach (addrs[i]) begin
      wdata = $urandom();
      local_write(addrs[i], 4'hF, wdata);
      shadow[addrs[i]] = wdata;
    end
    // Partial writes over the full words
    foreach (addrs[i]) begin
      wdata = $urandom();
      be    = be_t'($urandom_range(14, 1));
      local_write(addrs[i], be, wdata);
      shadow[addrs[i]] = merge_bytes(shadow[addrs[i]], wdata, be);
    end
    foreach (addrs[i]) begin
      local_read(addrs[i], shadow[addrs[i]], 1'b0);
    end
  endtask

  task automatic test_boot_table;
    data_t rdata;
    logic  err;
    int    cycles;
    for (int i = 0; i < 8; i++) begin
      local_read(BootTableAddr + addr_t'(4 * i), {16'hB007, 16'(i)}, 1'b0);
    end
    bus_access(1'b1, BootTableAddr + 32'h4, 4'hF, $urandom(), rdata, err, cycles);
    check_bit("mgr_err_o", err, 1'b1);
    check_data("mgr_rdata_o", rdata, 32'hBADCAB1E);
    local_read(PeriphBase + 32'h800, 32'hBADCAB1E, 1'b1);
  endtask

  task automatic test_control_writes;
    data_t new_boot;
    new_boot = $urandom();
    local_write(PeriphBase, 4'hF, new_boot);
    check_addr("boot_addr_o", boot_addr_o, new_boot);
    local_write(CtrlRegAddr, 4'hF, '0);
    check_bit("fetch_enable_o", fetch_enable_o, 1'b0);
    local_read(CtrlRegAddr, '0, 1'b0);
    fetch_enable_i = 1'b1;
    @(negedge clk_i);
    check_bit("fetch_enable_o", fetch_enable_o, 1'b1);
    @(posedge clk_i);
    #1;
    fetch_enable_i = 1'b0;
    @(negedge clk_i);
    check_bit("fetch_enable_o", fetch_enable_o, 1'b0);
    @(posedge clk_i);
    #1;
  endtask

  task automatic test_external;
    data_t rdata;
    data_t wdata;
    logic  err;
    int    cycles;
    bus_access(1'b0, 32'h8000_0000, 4'hF, '0, rdata, err, cycles);
    check_addr("ext_addr_o", seen_addr, 32'h8000_0000);
    check_bit("ext_we_o", seen_we, 1'b0);
    check_data("mgr_rdata_o", rdata, ext_read_word(32'h8000_0000));
    check_bit("mgr_err_o", err, 1'b0);
    wdata = $urandom();
    bus_access(1'b1, 32'h8000_0004, 4'h5, wdata, rdata, err, cycles);
    check_addr("ext_addr_o", seen_addr, 32'h8000_0004);
    check_bit("ext_we_o", seen_we, 1'b1);
    check_be("ext_be_o", seen_be, 4'h5);
    check_data("ext_wdata_o", seen_wdata, wdata);
    check_data("mgr_rdata_o", rdata, '0);
    check_bit("mgr_err_o", err, 1'b0);
    bus_access(1'b0, 32'h8000_000C, 4'hF, '0, rdata, err, cycles);
    check_data("mgr_rdata_o", rdata, ext_read_word(32'h8000_000C));
    check_bit("mgr_err_o", err, 1'b1);
  endtask

  // Back-to-back requests alternating external and bank routes
  task automatic test_ordering;
    addr_t addrs [6];
    data_t rdata;
    logic  err;
    int    cycles;
    addrs = '{32'h8000_0010, 32'h0000_0010, 32'h8000_002C,
              32'h0000_1010, 32'h8000_0020, 32'h0000_0ffc};
    fork
      begin
        foreach (addrs[i]) begin
          issue(addrs[i], 1'b0, 4'hF, '0);
        end
      end
      begin
        foreach (addrs[i]) begin
          wait_response(rdata, err, cycles);
          if (addrs[i][31]) begin
            check_data("mgr_rdata_o", rdata, ext_read_word(addrs[i]));
            check_bit("mgr_err_o", err, ext_read_err(addrs[i]));
          end else begin
            check_data("mgr_rdata_o", rdata, shadow[addrs[i]]);
            check_bit("mgr_err_o", err, 1'b0);
          end
        end
      end
    join
    @(posedge clk_i);
    #1;
  endtask

  // ------------------------------
  // External responder
  // ------------------------------
  initial begin : ext_responder
    int unsigned gnt_delay;
    ext_gnt_i    = 1'b0;
    ext_rvalid_i = 1'b0;
    ext_rdata_i  = '0;
    ext_err_i    = 1'b0;
    forever begin
      @(negedge clk_i);
      if (ext_req_o) begin
        gnt_delay = $urandom_range(3, 0);
        repeat (gnt_delay) @(posedge clk_i);
        @(posedge clk_i);
        #1;
        ext_gnt_i = 1'b1;
        @(negedge clk_i);
        seen_addr  = ext_addr_o;
        seen_we    = ext_we_o;
        seen_be    = ext_be_o;
        seen_wdata = ext_wdata_o;
        @(posedge clk_i);
        #1;
        ext_gnt_i = 1'b0;
        @(posedge clk_i);
        #1;
        ext_rvalid_i = 1'b1;
        ext_rdata_i  = seen_we ? '0 : ext_read_word(seen_addr);
        ext_err_i    = ext_read_err(seen_addr);
        @(posedge clk_i);
        #1;
        ext_rvalid_i = 1'b0;
      end
    end
  end

  initial begin : main_sequence
    void'($urandom(32'h1a17247b));
    run_done       = 1'b0;
    failed         = 1'b0;
    rst_ni         = 1'b0;
    bootmode_i     = BootJtag;
    fetch_enable_i = 1'b0;
    mgr_req_i      = 1'b0;
    mgr_addr_i     = '0;
    mgr_we_i       = 1'b0;
    mgr_be_i       = '0;
    mgr_wdata_i    = '0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    // Let the boot mode capture settle
    repeat (2) @(posedge clk_i);
    #1;
    test_boot_state();
    test_banks();
    test_boot_table();
    test_control_writes();
    test_external();
    test_ordering();
    run_done = 1'b1;
    $display(">>> PASS");
    $finish;
  end

  final begin
    if (!run_done && !failed) begin
      $display(">>> FAIL");
    end
  end

endmodule

`default_nettype wire

//--- sim/island_tb_properties.sv
`timescale 1ns/100ps
`default_nettype none

module island_tb_properties (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              mgr_req_i,
  input logic              mgr_gnt_o,
  input island_pkg::addr_t mgr_addr_i,
  input logic              mgr_we_i,
  input island_pkg::be_t   mgr_be_i,
  input island_pkg::data_t mgr_wdata_i,
  input logic              mgr_rvalid_o,
  input logic              ext_req_o,
  input logic              ext_gnt_i
);

  logic [2:0] outstanding_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= '0;
    end else begin
      outstanding_q <= outstanding_q + {2'b0, mgr_req_i && mgr_gnt_o} - {2'b0, mgr_rvalid_o};
    end
  end

  // Request held until granted
  req_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mgr_req_i && !mgr_gnt_o |=> mgr_req_i && $stable(mgr_addr_i) && $stable(mgr_we_i)
      && $stable(mgr_be_i) && $stable(mgr_wdata_i))
    else $error("manager request changed before its grant");

  rvalid_outstanding_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mgr_rvalid_o |-> outstanding_q != 3'd0)
    else $error("manager response without an outstanding transfer");

  ext_req_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ext_req_o && !ext_gnt_i |=> ext_req_o)
    else $error("external request dropped before its grant");

endmodule

bind island_top island_tb_properties i_props (.*);

`default_nettype wire

//--- hw/island_top.sv
`timescale 1ns/100ps
`default_nettype none

module island_top #(
  parameter island_pkg::addr_t BaseAddr     = '0,
  parameter int                BankNumBytes = 4096
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  island_pkg::bootmode_e bootmode_i,
  input  logic                  fetch_enable_i,
  input  logic                  mgr_req_i,
  output logic                  mgr_gnt_o,
  input  island_pkg::addr_t     mgr_addr_i,
  input  logic                  mgr_we_i,
  input  island_pkg::be_t       mgr_be_i,
  input  island_pkg::data_t     mgr_wdata_i,
  output logic                  mgr_rvalid_o,
  output island_pkg::data_t     mgr_rdata_o,
  output logic                  mgr_err_o,
  output logic                  ext_req_o,
  input  logic                  ext_gnt_i,
  output island_pkg::addr_t     ext_addr_o,
  output logic                  ext_we_o,
  output island_pkg::be_t       ext_be_o,
  output island_pkg::data_t     ext_wdata_o,
  input  logic                  ext_rvalid_i,
  input  island_pkg::data_t     ext_rdata_i,
  input  logic                  ext_err_i,
  output logic                  fetch_enable_o,
  output island_pkg::addr_t     boot_addr_o
);
  import island_pkg::*;

  logic  bank0_req, bank0_gnt, bank0_we, bank0_rvalid, bank0_err;
  addr_t bank0_addr;
  be_t   bank0_be;
  data_t bank0_wdata, bank0_rdata;

  logic  bank1_req, bank1_gnt, bank1_we, bank1_rvalid, bank1_err;
  addr_t bank1_addr;
  be_t   bank1_be;
  data_t bank1_wdata, bank1_rdata;

  logic  periph_req, periph_gnt, periph_we, periph_rvalid, periph_err;
  addr_t periph_addr;
  be_t   periph_be;
  data_t periph_wdata, periph_rdata;

  // ------------------------------
  // Interconnect
  // ------------------------------
  island_bus_demux #(
    .BaseAddr     ( BaseAddr     ),
    .BankNumBytes ( BankNumBytes )
  ) i_bus_demux (
    .clk_i,
    .rst_ni,
    .mgr_req_i, .mgr_gnt_o, .mgr_addr_i, .mgr_we_i, .mgr_be_i, .mgr_wdata_i,
    .mgr_rvalid_o, .mgr_rdata_o, .mgr_err_o,
    .bank0_req_o ( bank0_req ), .bank0_gnt_i ( bank0_gnt ), .bank0_addr_o ( bank0_addr ),
    .bank0_we_o ( bank0_we ), .bank0_be_o ( bank0_be ), .bank0_wdata_o ( bank0_wdata ),
    .bank0_rvalid_i ( bank0_rvalid ), .bank0_rdata_i ( bank0_rdata ),
    .bank0_err_i ( bank0_err ),
    .bank1_req_o ( bank1_req ), .bank1_gnt_i ( bank1_gnt ), .bank1_addr_o ( bank1_addr ),
    .bank1_we_o ( bank1_we ), .bank1_be_o ( bank1_be ), .bank1_wdata_o ( bank1_wdata ),
    .bank1_rvalid_i ( bank1_rvalid ), .bank1_rdata_i ( bank1_rdata ),
    .bank1_err_i ( bank1_err ),
    .periph_req_o ( periph_req ), .periph_gnt_i ( periph_gnt ),
    .periph_addr_o ( periph_addr ), .periph_we_o ( periph_we ),
    .periph_be_o ( periph_be ), .periph_wdata_o ( periph_wdata ),
    .periph_rvalid_i ( periph_rvalid ), .periph_rdata_i ( periph_rdata ),
    .periph_err_i ( periph_err ),
    .ext_req_o, .ext_gnt_i, .ext_addr_o, .ext_we_o, .ext_be_o, .ext_wdata_o,
    .ext_rvalid_i, .ext_rdata_i, .ext_err_i
  );

  // ------------------------------
  // Memories
  // ------------------------------
  island_sram_bank #(
    .BankNumBytes ( BankNumBytes )
  ) i_bank0 (
    .clk_i,
    .rst_ni,
    .req_i ( bank0_req ), .gnt_o ( bank0_gnt ), .addr_i ( bank0_addr ), .we_i ( bank0_we ),
    .be_i ( bank0_be ), .wdata_i ( bank0_wdata ),
    .rvalid_o ( bank0_rvalid ), .rdata_o ( bank0_rdata ), .err_o ( bank0_err )
  );

  island_sram_bank #(
    .BankNumBytes ( BankNumBytes )
  ) i_bank1 (
    .clk_i,
    .rst_ni,
    .req_i ( bank1_req ), .gnt_o ( bank1_gnt ), .addr_i ( bank1_addr ), .we_i ( bank1_we ),
    .be_i ( bank1_be ), .wdata_i ( bank1_wdata ),
    .rvalid_o ( bank1_rvalid ), .rdata_o ( bank1_rdata ), .err_o ( bank1_err )
  );

  // ------------------------------
  // Peripherals and SoC control
  // ------------------------------
  island_periph_block #(
    .BaseAddr ( BaseAddr )
  ) i_periph_block (
    .clk_i,
    .rst_ni,
    .req_i ( periph_req ), .gnt_o ( periph_gnt ), .addr_i ( periph_addr ),
    .we_i ( periph_we ), .be_i ( periph_be ), .wdata_i ( periph_wdata ),
    .rvalid_o ( periph_rvalid ), .rdata_o ( periph_rdata ), .err_o ( periph_err ),
    .bootmode_i,
    .fetch_enable_i,
    .fetch_enable_o,
    .boot_addr_o
  );

endmodule

`default_nettype wire

//--- hw/island_bus_demux.sv
`timescale 1ns/100ps
`default_nettype none

module island_bus_demux #(
  parameter island_pkg::addr_t BaseAddr     = '0,
  parameter int                BankNumBytes = 4096
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              mgr_req_i,
  output logic              mgr_gnt_o,
  input  island_pkg::addr_t mgr_addr_i,
  input  logic              mgr_we_i,
  input  island_pkg::be_t   mgr_be_i,
  input  island_pkg::data_t mgr_wdata_i,
  output logic              mgr_rvalid_o,
  output island_pkg::data_t mgr_rdata_o,
  output logic              mgr_err_o,
  output logic              bank0_req_o,
  input  logic              bank0_gnt_i,
  output island_pkg::addr_t bank0_addr_o,
  output logic              bank0_we_o,
  output island_pkg::be_t   bank0_be_o,
  output island_pkg::data_t bank0_wdata_o,
  input  logic              bank0_rvalid_i,
  input  island_pkg::data_t bank0_rdata_i,
  input  logic              bank0_err_i,
  output logic              bank1_req_o,
  input  logic              bank1_gnt_i,
  output island_pkg::addr_t bank1_addr_o,
  output logic              bank1_we_o,
  output island_pkg::be_t   bank1_be_o,
  output island_pkg::data_t bank1_wdata_o,
  input  logic              bank1_rvalid_i,
  input  island_pkg::data_t bank1_rdata_i,
  input  logic              bank1_err_i,
  output logic              periph_req_o,
  input  logic              periph_gnt_i,
  output island_pkg::addr_t periph_addr_o,
  output logic              periph_we_o,
  output island_pkg::be_t   periph_be_o,
  output island_pkg::data_t periph_wdata_o,
  input  logic              periph_rvalid_i,
  input  island_pkg::data_t periph_rdata_i,
  input  logic              periph_err_i,
  output logic              ext_req_o,
  input  logic              ext_gnt_i,
  output island_pkg::addr_t ext_addr_o,
  output logic              ext_we_o,
  output island_pkg::be_t   ext_be_o,
  output island_pkg::data_t ext_wdata_o,
  input  logic              ext_rvalid_i,
  input  island_pkg::data_t ext_rdata_i,
  input  logic              ext_err_i
);
  import island_pkg::*;

  localparam addr_t Bank1Base  = BaseAddr + addr_t'(BankNumBytes);
  localparam addr_t Bank1End   = Bank1Base + addr_t'(BankNumBytes);
  localparam addr_t PeriphBase = BaseAddr + PeriphOffset;

  route_e     route;
  route_e     route_q;
  logic [1:0] pending_q;
  logic       stall;
  logic       sel_gnt;
  logic       rsp_valid;

  // ------------------------------
  // Address decode
  // ------------------------------
  always_comb begin
    route = RouteExt;
    if (mgr_addr_i >= BaseAddr && mgr_addr_i < Bank1Base) begin
      route = RouteBank0;
    end else if (mgr_addr_i >= Bank1Base && mgr_addr_i < Bank1End) begin
      route = RouteBank1;
    end else if (mgr_addr_i >= PeriphBase && mgr_addr_i < PeriphBase + PeriphRange) begin
      route = RoutePeriph;
    end
  end

  // Only one route in flight at a time keeps responses in order
  assign stall = (pending_q == 2'd2) || (pending_q != 2'd0 && route != route_q);

  always_comb begin
    case (route)
      RouteBank0:  sel_gnt = bank0_gnt_i;
      RouteBank1:  sel_gnt = bank1_gnt_i;
      RoutePeriph: sel_gnt = periph_gnt_i;
      default:     sel_gnt = ext_gnt_i;
    endcase
  end

  assign mgr_gnt_o   = mgr_req_i && !stall && sel_gnt;

  assign bank0_req_o  = mgr_req_i && !stall && route == RouteBank0;
  assign bank1_req_o  = mgr_req_i && !stall && route == RouteBank1;
  assign periph_req_o = mgr_req_i && !stall && route == RoutePeriph;
  assign ext_req_o    = mgr_req_i && !stall && route == RouteExt;

  assign bank0_addr_o   = mgr_addr_i;
  assign bank0_we_o     = mgr_we_i;
  assign bank0_be_o     = mgr_be_i;
  assign bank0_wdata_o  = mgr_wdata_i;
  assign bank1_addr_o   = mgr_addr_i;
  assign bank1_we_o     = mgr_we_i;
  assign bank1_be_o     = mgr_be_i;
  assign bank1_wdata_o  = mgr_wdata_i;
  assign periph_addr_o  = mgr_addr_i;
  assign periph_we_o    = mgr_we_i;
  assign periph_be_o    = mgr_be_i;
  assign periph_wdata_o = mgr_wdata_i;
  assign ext_addr_o     = mgr_addr_i;
  assign ext_we_o       = mgr_we_i;
  assign ext_be_o       = mgr_be_i;
  assign ext_wdata_o    = mgr_wdata_i;

  // ------------------------------
  // Response return
  // ------------------------------
  always_comb begin
    case (route_q)
      RouteBank0: begin
        rsp_valid   = bank0_rvalid_i;
        mgr_rdata_o = bank0_rdata_i;
        mgr_err_o   = bank0_err_i;
      end
      RouteBank1: begin
        rsp_valid   = bank1_rvalid_i;
        mgr_rdata_o = bank1_rdata_i;
        mgr_err_o   = bank1_err_i;
      end
      RoutePeriph: begin
        rsp_valid   = periph_rvalid_i;
        mgr_rdata_o = periph_rdata_i;
        mgr_err_o   = periph_err_i;
      end
      default: begin
        rsp_valid   = ext_rvalid_i;
        mgr_rdata_o = ext_rdata_i;
        mgr_err_o   = ext_err_i;
      end
    endcase
  end

  assign mgr_rvalid_o = rsp_valid && pending_q != 2'd0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 2'd0;
      route_q   <= RouteExt;
    end else begin
      if (mgr_gnt_o) begin
        route_q <= route;
      end
      pending_q <= pending_q + {1'b0, mgr_gnt_o} - {1'b0, mgr_rvalid_o};
    end
  end

endmodule

`default_nettype wire

//--- hw/island_periph_block.sv
`timescale 1ns/100ps
`default_nettype none

module island_periph_block #(
  parameter island_pkg::addr_t BaseAddr = '0
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_i,
  output logic                  gnt_o,
  input  island_pkg::addr_t     addr_i,
  input  logic                  we_i,
  input  island_pkg::be_t       be_i,
  input  island_pkg::data_t     wdata_i,
  output logic                  rvalid_o,
  output island_pkg::data_t     rdata_o,
  output logic                  err_o,
  input  island_pkg::bootmode_e bootmode_i,
  input  logic                  fetch_enable_i,
  output logic                  fetch_enable_o,
  output island_pkg::addr_t     boot_addr_o
);
  import island_pkg::*;

  localparam addr_t PeriphBase = BaseAddr + PeriphOffset;

  addr_t      offset;
  logic       sel_ctrl;
  logic       sel_rom;
  logic [5:0] rom_idx;
  data_t      rom_word;
  logic       ctrl_rvalid;
  data_t      ctrl_rdata;
  logic       loc_valid_q;
  logic       loc_err_q;
  data_t      loc_rdata_q;

  // ------------------------------
  // Peripheral decode
  // ------------------------------
  assign offset   = addr_i - PeriphBase;
  assign sel_ctrl = offset >= SocCtrlOffset && offset < SocCtrlOffset + BlockRange;
  // Boot table is read only, writes land on the error path
  assign sel_rom  = !we_i && offset >= BootRomOffset && offset < BootRomOffset + BlockRange;
  assign gnt_o    = 1'b1;

  assign rom_idx  = offset[7:2];
  assign rom_word = (rom_idx < BootRomWords) ? {BootRomTag, 10'd0, rom_idx} : '0;

  island_soc_ctrl #(
    .PeriphBase ( PeriphBase )
  ) i_soc_ctrl (
    .clk_i,
    .rst_ni,
    .reg_req_i      ( req_i && sel_ctrl       ),
    .reg_we_i       ( we_i                    ),
    .reg_addr_i     ( offset - SocCtrlOffset  ),
    .reg_wdata_i    ( wdata_i                 ),
    .reg_be_i       ( be_i                    ),
    .reg_rvalid_o   ( ctrl_rvalid             ),
    .reg_rdata_o    ( ctrl_rdata              ),
    .bootmode_i,
    .fetch_enable_i,
    .fetch_enable_o,
    .boot_addr_o
  );

  // ------------------------------
  // Boot table and error response
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      loc_valid_q <= 1'b0;
    end else begin
      loc_valid_q <= req_i && !sel_ctrl;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i && !sel_ctrl) begin
      loc_err_q   <= !sel_rom;
      loc_rdata_q <= sel_rom ? rom_word : ErrRspData;
    end
  end

  // Never both valid, only one access per cycle
  assign rvalid_o = loc_valid_q | ctrl_rvalid;
  assign rdata_o  = loc_valid_q ? loc_rdata_q : ctrl_rdata;
  assign err_o    = loc_valid_q & loc_err_q;

endmodule

`default_nettype wire

//--- hw/island_soc_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module island_soc_ctrl #(
  parameter island_pkg::addr_t PeriphBase = 32'h0020_0000
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  reg_req_i,
  input  logic                  reg_we_i,
  input  island_pkg::addr_t     reg_addr_i,
  input  island_pkg::data_t     reg_wdata_i,
  input  island_pkg::be_t       reg_be_i,
  output logic                  reg_rvalid_o,
  output island_pkg::data_t     reg_rdata_o,
  input  island_pkg::bootmode_e bootmode_i,
  input  logic                  fetch_enable_i,
  output logic                  fetch_enable_o,
  output island_pkg::addr_t     boot_addr_o
);
  import island_pkg::*;

  localparam addr_t BootAddrReset = PeriphBase + BootRomOffset + BootEntryOffset;

  logic           first_cycle_q;
  addr_t          boot_addr_q;
  soc_ctrl_word_u ctrl_q;
  logic [7:0]     reg_offset;
  data_t          wmask;

  assign reg_offset = reg_addr_i[7:0];

  always_comb begin
    for (int b = 0; b < BeWidth; b++) begin
      wmask[8*b +: 8] = {8{reg_be_i[b]}};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_cycle_q <= 1'b1;
      reg_rvalid_o  <= 1'b0;
    end else begin
      first_cycle_q <= 1'b0;
      reg_rvalid_o  <= reg_req_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      boot_addr_q <= BootAddrReset;
    end else if (reg_req_i && reg_we_i && reg_offset == BootAddrReg) begin
      boot_addr_q <= (boot_addr_q & ~wmask) | (reg_wdata_i & wmask);
    end
  end

  // Boot mode sampled once, right after reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_q <= '0;
    end else if (first_cycle_q) begin
      ctrl_q.fields.bootmode <= bootmode_i;
      ctrl_q.fields.fetchen  <= (bootmode_i == BootJtag);
    end else if (reg_req_i && reg_we_i && reg_offset == CtrlReg) begin
      ctrl_q.raw <= (ctrl_q.raw & ~wmask) | (reg_wdata_i & wmask);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reg_req_i) begin
      if (reg_we_i) begin
        reg_rdata_o <= '0;
      end else begin
        case (reg_offset)
          BootAddrReg: reg_rdata_o <= boot_addr_q;
          CtrlReg:     reg_rdata_o <= ctrl_q.raw;
          default:     reg_rdata_o <= '0;
        endcase
      end
    end
  end

  assign fetch_enable_o = ctrl_q.fields.fetchen | fetch_enable_i;
  assign boot_addr_o    = boot_addr_q;

endmodule

`default_nettype wire

//--- hw/island_sram_bank.sv
`timescale 1ns/100ps
`default_nettype none

module island_sram_bank #(
  parameter int BankNumBytes = 4096
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_i,
  output logic              gnt_o,
  input  island_pkg::addr_t addr_i,
  input  logic              we_i,
  input  island_pkg::be_t   be_i,
  input  island_pkg::data_t wdata_i,
  output logic              rvalid_o,
  output island_pkg::data_t rdata_o,
  output logic              err_o
);
  import island_pkg::*;

  localparam int NumWords = BankNumBytes / 4;
  localparam int IdxWidth = $clog2(NumWords);

  data_t               mem_q [NumWords];
  logic [IdxWidth-1:0] idx;

  // Word index above the byte offset
  assign idx   = addr_i[IdxWidth+1:2];
  assign gnt_o = 1'b1;
  assign err_o = 1'b0;

  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < BeWidth; b++) begin
        if (be_i[b]) begin
          mem_q[idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= we_i ? '0 : mem_q[idx];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i;
    end
  end

endmodule

`default_nettype wire

//--- hw/island_pkg.sv
`default_nettype none

package island_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned BeWidth   = DataWidth / 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [BeWidth-1:0]   be_t;

  // ------------------------------
  // Address map
  // ------------------------------
  localparam addr_t PeriphOffset  = 32'h0020_0000;
  localparam addr_t PeriphRange   = 32'h0000_1000;
  localparam addr_t SocCtrlOffset = 32'h0000_0000;
  localparam addr_t BootRomOffset = 32'h0000_0100;
  // Every peripheral block spans the same range
  localparam addr_t BlockRange    = 32'h0000_0100;

  // Boot table layout
  localparam int unsigned BootRomWords    = 8;
  localparam logic [15:0] BootRomTag      = 16'hB007;
  localparam addr_t       BootEntryOffset = 32'h0000_0080;

  // SoC control registers
  localparam logic [7:0] BootAddrReg = 8'h00;
  localparam logic [7:0] CtrlReg     = 8'h04;

  localparam data_t ErrRspData = 32'hBADCAB1E;

  typedef enum logic [1:0] {
    BootPreload = 2'd0,
    BootJtag    = 2'd1,
    BootSpi     = 2'd2
  } bootmode_e;

  // Bus side sees raw, control logic sees fields
  typedef union packed {
    data_t raw;
    struct packed {
      logic [28:0] reserved;
      bootmode_e   bootmode;
      logic        fetchen;
    } fields;
  } soc_ctrl_word_u;

  typedef enum logic [1:0] {
    RouteExt    = 2'd0,
    RouteBank0  = 2'd1,
    RouteBank1  = 2'd2,
    RoutePeriph = 2'd3
  } route_e;

endpackage

`default_nettype wire
